//--- cache_cfg.svh
// Address width, cache geometry and memory read latency macros
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

//////////////////////////////////////////////////
// Address and data
//////////////////////////////////////////////////

// Byte address, bit 0 always ignored
`define CACHE_ADDR_W 16
// One memory word
`define CACHE_WORD_W 16

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

`define CACHE_SETS 32
`define CACHE_BLK_WORDS 8

// Derived field widths, tag takes what is left above the index
`define CACHE_OFFSET_W ($clog2(`CACHE_BLK_WORDS))
`define CACHE_INDEX_W ($clog2(`CACHE_SETS))
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W - 1)

// Cycles from read enable to rvalid
`define MEM_RD_LAT 4

`endif

//--- cache_pkg.sv
// Cache package: address, word and field types, request opcode and controller state enums
package cache_pkg;

`include "cache_cfg.svh"

   //////////////////////////////////////////////////
   // Data and address types
   //////////////////////////////////////////////////

   // Byte address
   typedef logic [`CACHE_ADDR_W-1:0] addr_t;
   // Data word
   typedef logic [`CACHE_WORD_W-1:0] word_t;

   // Address fields
   typedef logic [`CACHE_TAG_W-1:0] tag_t;
   typedef logic [`CACHE_INDEX_W-1:0] index_t;
   typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

   //////////////////////////////////////////////////
   // Enums
   //////////////////////////////////////////////////

   // Request opcode
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } req_op_e;

   // Controller FSM
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_FILL    = 2'd1,
      ST_RESPOND = 2'd2
   } ctrl_state_e;

endpackage

//--- cache_ifs.sv
// Interfaces mem_bus_if and cache_array_if with their modports
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Controller to main memory
//////////////////////////////////////////////////

interface mem_bus_if;
   // Request side, from the controller
   logic             enable;
   logic             wr;
   cache_pkg::addr_t addr;
   cache_pkg::word_t wdata;
   // Read return, fixed latency after enable
   cache_pkg::word_t rdata;
   logic             rvalid;

   modport master (
      output enable, wr, addr, wdata,
      input  rdata, rvalid
   );

   modport slave (
      input  enable, wr, addr, wdata,
      output rdata, rvalid
   );
endinterface

//////////////////////////////////////////////////
// Controller to data and tag arrays
//////////////////////////////////////////////////

interface cache_array_if;
   // Shared lookup position
   cache_pkg::index_t  index;
   cache_pkg::offset_t offset;
   // Write port
   cache_pkg::word_t   wdata;
   logic               data_we;
   logic               tag_we;
   // Lookup results
   cache_pkg::word_t   rdata;
   logic               hit;

   modport ctrl (
      output index, offset, wdata, data_we, tag_we,
      input  rdata, hit
   );

   // Data array sees offset, tag array does not
   modport data (
      input  index, offset, wdata, data_we,
      output rdata
   );

   modport tag (
      input  index, tag_we,
      output hit
   );
endinterface

//--- main_memory.sv
// Word-organized main memory, single-cycle write and fixed-latency pipelined read
`timescale 1ns/1ps
`include "cache_cfg.svh"

module main_memory #(
   parameter int ADDR_WIDTH = `CACHE_ADDR_W
) (
   input logic       clk,
   input logic       rst,
   mem_bus_if.slave  bus
);

   // Bit 0 selects a byte, so one word per even address
   localparam int WORD_AW = ADDR_WIDTH - 1;
   localparam int DEPTH   = 2 ** WORD_AW;
   localparam int LAT     = `MEM_RD_LAT;

   // Storage, contents undefined until written
   cache_pkg::word_t mem [DEPTH];

   logic [WORD_AW-1:0] word_addr;
   logic               rd_en;
   logic               wr_en;

   // Read return pipeline, stage 0 sampled at the enable edge
   cache_pkg::word_t rd_pipe [LAT];
   logic [LAT-1:0]   vld_pipe;

   assign word_addr = bus.addr[ADDR_WIDTH-1:1];
   assign rd_en     = bus.enable && !bus.wr;
   assign wr_en     = bus.enable && bus.wr;

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[word_addr] <= bus.wdata;
      end
   end

   //////////////////////////////////////////////////
   // Read pipeline
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < LAT; i++) begin
            rd_pipe[i] <= '0;
         end
         vld_pipe <= '0;
      end else begin
         // Idle stages carry zero data
         rd_pipe[0]  <= rd_en ? mem[word_addr] : '0;
         vld_pipe[0] <= rd_en;
         for (int i = 1; i < LAT; i++) begin
            rd_pipe[i]  <= rd_pipe[i-1];
            vld_pipe[i] <= vld_pipe[i-1];
         end
      end
   end

   // Last stage drives the return
   assign bus.rdata  = rd_pipe[LAT-1];
   assign bus.rvalid = vld_pipe[LAT-1];

endmodule

//--- cache_data_array.sv
// Cache data array: one word per set and offset, combinational read, clocked word write
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data_array (
   input logic          clk,
   cache_array_if.data  arr
);

   localparam int SETS = `CACHE_SETS;
   localparam int BLK  = `CACHE_BLK_WORDS;

   //////////////////////////////////////////////////
   // Block storage
   //////////////////////////////////////////////////

   // Set-major layout, each set holds one full block
   cache_pkg::word_t blocks [SETS][BLK];

   //////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////

   // Hit path reads in the request cycle
   // Respond path reads the latched miss offset
   assign arr.rdata = blocks[arr.index][arr.offset];

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   // Write hits and fill returns share this port
   // Only one of them is active in any cycle
   always_ff @(posedge clk) begin
      if (arr.data_we) begin
         blocks[arr.index][arr.offset] <= arr.wdata;
      end
   end

endmodule

//--- cache_tag_array.sv
// Cache tag array: tag and valid bit per set, hit compare and clocked update
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tag_array (
   input logic            clk,
   input logic            rst,
   cache_array_if.tag     arr,
   input cache_pkg::tag_t lookup_tag
);

   localparam int SETS = `CACHE_SETS;

   //////////////////////////////////////////////////
   // Tag and valid storage
   //////////////////////////////////////////////////

   cache_pkg::tag_t tags [SETS];
   logic [SETS-1:0] valid;

   // Indexed entry
   cache_pkg::tag_t entry_tag;
   logic            entry_valid;

   assign entry_tag   = tags[arr.index];
   assign entry_valid = valid[arr.index];

   //////////////////////////////////////////////////
   // Hit compare
   //////////////////////////////////////////////////

   // Valid entry with matching tag
   assign arr.hit = entry_valid && (entry_tag == lookup_tag);

   //////////////////////////////////////////////////
   // Update
   //////////////////////////////////////////////////

   // Every set starts invalid
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (arr.tag_we) begin
         valid[arr.index] <= 1'b1;
      end
   end

   // Fill completion installs the miss tag
   always_ff @(posedge clk) begin
      if (arr.tag_we) begin
         tags[arr.index] <= lookup_tag;
      end
   end

endmodule

//--- cache_ctrl.sv
// Cache controller: request decode, hit path, write-through and block-fill FSM
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_valid,
   input  cache_pkg::req_op_e req_op,
   input  cache_pkg::addr_t   req_addr,
   input  cache_pkg::word_t   req_wdata,
   output logic               stall,
   output logic               rd_valid,
   output logic               hit,
   output cache_pkg::word_t   rd_data,
   output cache_pkg::tag_t    lookup_tag,
   cache_array_if.ctrl        arr,
   mem_bus_if.master          mem
);

   // Address field positions
   localparam int OFF_LSB = 1;
   localparam int IDX_LSB = OFF_LSB + `CACHE_OFFSET_W;
   localparam int TAG_LSB = IDX_LSB + `CACHE_INDEX_W;

   // Issue counter needs one extra bit to mark completion
   localparam int CNT_W = `CACHE_OFFSET_W + 1;
   localparam logic [CNT_W-1:0] ISSUE_END = CNT_W'(`CACHE_BLK_WORDS);
   localparam cache_pkg::offset_t LAST_OFF = cache_pkg::offset_t'(`CACHE_BLK_WORDS - 1);

   // Incoming request fields
   cache_pkg::offset_t req_off;
   cache_pkg::index_t  req_idx;
   cache_pkg::tag_t    req_tag;

   // Latched miss address and its fields
   cache_pkg::addr_t   miss_addr;
   cache_pkg::offset_t miss_off;
   cache_pkg::index_t  miss_idx;
   cache_pkg::tag_t    miss_tag;

   cache_pkg::ctrl_state_e state;
   logic [CNT_W-1:0]       issue_cnt;
   cache_pkg::offset_t     ret_cnt;

   logic accept;
   logic is_write;
   logic in_fill;
   logic issuing;
   logic last_ret;

   assign req_off  = req_addr[OFF_LSB +: `CACHE_OFFSET_W];
   assign req_idx  = req_addr[IDX_LSB +: `CACHE_INDEX_W];
   assign req_tag  = req_addr[TAG_LSB +: `CACHE_TAG_W];
   assign miss_off = miss_addr[OFF_LSB +: `CACHE_OFFSET_W];
   assign miss_idx = miss_addr[IDX_LSB +: `CACHE_INDEX_W];
   assign miss_tag = miss_addr[TAG_LSB +: `CACHE_TAG_W];

   // Busy for the whole fill and the respond cycle
   assign stall    = (state != cache_pkg::ST_IDLE);
   assign accept   = req_valid && (state == cache_pkg::ST_IDLE);
   assign is_write = (req_op == cache_pkg::OP_WRITE);
   assign in_fill  = (state == cache_pkg::ST_FILL);
   // Reads go out on consecutive cycles until all offsets are issued
   assign issuing  = in_fill && (issue_cnt != ISSUE_END);
   assign last_ret = in_fill && mem.rvalid && (ret_cnt == LAST_OFF);

   //////////////////////////////////////////////////
   // Array and memory drive
   //////////////////////////////////////////////////

   always_comb begin
      // Defaults follow the incoming request
      arr.index  = req_idx;
      arr.offset = req_off;
      arr.wdata  = req_wdata;
      lookup_tag = req_tag;
      mem.addr   = req_addr;
      case (state)
         cache_pkg::ST_FILL: begin
            // Returns land at the return counter
            arr.index  = miss_idx;
            arr.offset = ret_cnt;
            arr.wdata  = mem.rdata;
            lookup_tag = miss_tag;
            mem.addr   = {miss_tag, miss_idx, issue_cnt[`CACHE_OFFSET_W-1:0], 1'b0};
         end
         cache_pkg::ST_RESPOND: begin
            arr.index  = miss_idx;
            arr.offset = miss_off;
            lookup_tag = miss_tag;
         end
         default: begin
         end
      endcase
   end

   // Write hit updates the cached copy, fill returns fill the block
   assign arr.data_we = (accept && is_write && arr.hit) || (in_fill && mem.rvalid);
   // Tag goes valid with the last word
   assign arr.tag_we  = last_ret;

   // Writes go straight through, fill issues reads
   assign mem.enable = (accept && is_write) || issuing;
   assign mem.wr     = accept && is_write;
   assign mem.wdata  = req_wdata;

   //////////////////////////////////////////////////
   // FSM and response flags
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= cache_pkg::ST_IDLE;
         issue_cnt <= '0;
         ret_cnt   <= '0;
         rd_valid  <= 1'b0;
         hit       <= 1'b0;
      end else begin
         // Single-cycle pulses
         rd_valid <= 1'b0;
         hit      <= 1'b0;
         case (state)
            cache_pkg::ST_IDLE: begin
               if (accept) begin
                  hit <= arr.hit;
                  if (!is_write && arr.hit) begin
                     rd_valid <= 1'b1;
                  end else if (!is_write) begin
                     // Read miss starts a fill
                     state     <= cache_pkg::ST_FILL;
                     issue_cnt <= '0;
                     ret_cnt   <= '0;
                  end
               end
            end
            cache_pkg::ST_FILL: begin
               if (issuing) begin
                  issue_cnt <= issue_cnt + 1'b1;
               end
               if (mem.rvalid) begin
                  ret_cnt <= ret_cnt + 1'b1;
               end
               if (last_ret) begin
                  state <= cache_pkg::ST_RESPOND;
               end
            end
            cache_pkg::ST_RESPOND: begin
               // Miss response, hit stays low
               rd_valid <= 1'b1;
               state    <= cache_pkg::ST_IDLE;
            end
            default: begin
               state <= cache_pkg::ST_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Read data and miss address
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if ((accept && !is_write && arr.hit) || (state == cache_pkg::ST_RESPOND)) begin
         rd_data <= arr.rdata;
      end
      if (accept && !is_write && !arr.hit) begin
         miss_addr <= req_addr;
      end
   end

endmodule

//--- cache_top.sv
// Cache top level: controller, data array, tag array and main memory
`timescale 1ns/1ps

module cache_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_valid,
   input  cache_pkg::req_op_e req_op,
   input  cache_pkg::addr_t   req_addr,
   input  cache_pkg::word_t   req_wdata,
   output logic               stall,
   output logic               rd_valid,
   output cache_pkg::word_t   rd_data,
   output logic               hit
);

   // Controller to memory
   mem_bus_if     mem_bus ();
   // Controller to both arrays
   cache_array_if arr_bus ();

   // Tag to compare, request tag or latched miss tag
   cache_pkg::tag_t lookup_tag;

   //////////////////////////////////////////////////
   // Controller
   //////////////////////////////////////////////////

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req_op     (req_op),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .stall      (stall),
      .rd_valid   (rd_valid),
      .hit        (hit),
      .rd_data    (rd_data),
      .lookup_tag (lookup_tag),
      .arr        (arr_bus.ctrl),
      .mem        (mem_bus.master)
   );

   //////////////////////////////////////////////////
   // Arrays and backing memory
   //////////////////////////////////////////////////

   cache_data_array u_data (
      .clk (clk),
      .arr (arr_bus.data)
   );

   cache_tag_array u_tag (
      .clk        (clk),
      .rst        (rst),
      .arr        (arr_bus.tag),
      .lookup_tag (lookup_tag)
   );

   main_memory u_mem (
      .clk (clk),
      .rst (rst),
      .bus (mem_bus.slave)
   );

endmodule

//--- cache_tb.sv
// Directed-test testbench for the cache top level with reference model, LFSR and timeout
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;

   //////////////////////////////////////////////////
   // Test constants
   //////////////////////////////////////////////////

   localparam int RESET_CYCLES = 8;
   // Block-aligned bases in set 4 with tags 0x15 and 0x16
   localparam cache_pkg::addr_t BASE_A = 16'h2a40;
   localparam cache_pkg::addr_t BASE_B = 16'h2c40;
   // 1 KB region for the random mix
   localparam cache_pkg::addr_t RAND_BASE = 16'h8000;
   localparam int RAND_WORDS   = 512;
   localparam int RAND_OPS     = 200;
   localparam int THRASH_READS = 6;
   // Request count over all tests
   localparam int N_REQ = 9 + 7 + 12 + THRASH_READS + RAND_WORDS + RAND_OPS;
   // At most 40 cycles per request
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 + N_REQ * 40;

   logic               clk;
   logic               rst;
   logic               req_valid;
   cache_pkg::req_op_e req_op;
   cache_pkg::addr_t   req_addr;
   cache_pkg::word_t   req_wdata;
   logic               stall;
   logic               rd_valid;
   logic               hit;
   cache_pkg::word_t   rd_data;

   // Reference word memory plus tag and valid per set
   cache_pkg::word_t       ref_mem [2 ** (`CACHE_ADDR_W - 1)];
   logic [6:0]             ref_tag [`CACHE_SETS];
   logic [`CACHE_SETS-1:0] ref_valid;

   logic [31:0] lfsr;
   int          cycles = 0;

   cache_top cache_top_i (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .stall     (stall),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .hit       (hit)
   );

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Run limit from the request count
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("Simulation timed out after %0d cycles", cycles));
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers and checks
   //////////////////////////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                             input string what);
      if (got !== exp) begin
         fail_run($sformatf("** Error at %0t: %s data %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_hit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("** Error at %0t: %s hit %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_latency(input int got, input int exp, input string what);
      if (got != exp) begin
         fail_run($sformatf("** Error at %0t: %s latency %0d, expected %0d",
                            $time, what, got, exp));
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   function automatic cache_pkg::word_t rand_word();
      return cache_pkg::word_t'(rand_bits(16));
   endfunction

   // Byte address of word i after base
   function automatic cache_pkg::addr_t word_at(input cache_pkg::addr_t base, input int i);
      return base + cache_pkg::addr_t'(2 * i);
   endfunction

   // Drive one request and wait for its response
   // lat counts cycles after acceptance
   task automatic issue_request(input cache_pkg::req_op_e op, input cache_pkg::addr_t addr,
                                input cache_pkg::word_t wdata, output cache_pkg::word_t data,
                                output logic got_hit, output logic saw_stall, output int lat);
      @(posedge clk);
      req_valid <= 1'b1;
      req_op    <= op;
      req_addr  <= addr;
      req_wdata <= wdata;
      // Accepted at this edge since stall is low between requests
      @(posedge clk);
      req_valid <= 1'b0;
      saw_stall = 1'b0;
      data      = '0;
      @(negedge clk);
      lat = 1;
      if (op == cache_pkg::OP_WRITE) begin
         if (rd_valid || stall) begin
            fail_run("rd_valid or stall went high after a write");
         end
         got_hit = hit;
      end else begin
         while (!rd_valid) begin
            saw_stall = saw_stall | stall;
            @(negedge clk);
            lat++;
         end
         if (stall) begin
            fail_run("stall was still high in the rd_valid cycle");
         end
         got_hit = hit;
         data    = rd_data;
      end
   endtask

   // Request checked against the reference model
   task automatic checked_access(input cache_pkg::req_op_e op, input cache_pkg::addr_t addr,
                                 input cache_pkg::word_t wdata, output logic got_hit);
      logic [6:0]       tag;
      logic [4:0]       idx;
      logic             exp_hit;
      logic             saw_stall;
      int               lat;
      cache_pkg::word_t data;
      string            what;
      tag     = addr[15:9];
      idx     = addr[8:4];
      exp_hit = ref_valid[idx] && (ref_tag[idx] == tag);
      what    = $sformatf("%s at %h", op.name(), addr);
      issue_request(op, addr, wdata, data, got_hit, saw_stall, lat);
      check_hit(got_hit, exp_hit, what);
      if (op == cache_pkg::OP_WRITE) begin
         // Writes never allocate
         ref_mem[addr[15:1]] = wdata;
      end else begin
         check_word(data, ref_mem[addr[15:1]], what);
         if (exp_hit) begin
            check_latency(lat, 1, what);
         end else begin
            if (!saw_stall) begin
               fail_run($sformatf("stall never went high before the miss response (%s)", what));
            end
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic write_through_no_alloc();
      logic h;
      // Uncached block goes to memory only
      for (int i = 0; i < 8; i++) begin
         checked_access(cache_pkg::OP_WRITE, word_at(BASE_A, i), rand_word(), h);
         check_hit(h, 1'b0, "write to uncached block");
      end
      checked_access(cache_pkg::OP_READ, word_at(BASE_A, 3), '0, h);
      check_hit(h, 1'b0, "first read of block A");
   endtask

   task automatic fill_then_hit();
      logic h;
      for (int i = 0; i < 8; i++) begin
         if (i != 3) begin
            checked_access(cache_pkg::OP_READ, word_at(BASE_A, i), '0, h);
            check_hit(h, 1'b1, "read of filled block");
         end
      end
   endtask

   task automatic write_hit_evict();
      logic h;
      checked_access(cache_pkg::OP_WRITE, word_at(BASE_A, 5), rand_word(), h);
      check_hit(h, 1'b1, "write to cached word");
      checked_access(cache_pkg::OP_READ, word_at(BASE_A, 5), '0, h);
      // Same index with the other tag
      for (int i = 0; i < 8; i++) begin
         checked_access(cache_pkg::OP_WRITE, word_at(BASE_B, i), rand_word(), h);
      end
      checked_access(cache_pkg::OP_READ, word_at(BASE_B, 0), '0, h);
      // Refill must bring the written value from memory
      checked_access(cache_pkg::OP_READ, word_at(BASE_A, 5), '0, h);
      check_hit(h, 1'b0, "read after eviction");
   endtask

   task automatic conflict_thrash();
      logic h;
      for (int i = 0; i < THRASH_READS; i++) begin
         checked_access(cache_pkg::OP_READ, word_at((i % 2 == 0) ? BASE_B : BASE_A, 2), '0, h);
         check_hit(h, 1'b0, "conflict read");
      end
   endtask

   task automatic random_mix();
      logic        h;
      logic [31:0] op_bit;
      logic [31:0] w;
      for (int i = 0; i < RAND_WORDS; i++) begin
         checked_access(cache_pkg::OP_WRITE, word_at(RAND_BASE, i), rand_word(), h);
      end
      for (int i = 0; i < RAND_OPS; i++) begin
         op_bit = rand_bits(1);
         w      = rand_bits(9);
         checked_access(op_bit[0] ? cache_pkg::OP_WRITE : cache_pkg::OP_READ,
                        word_at(RAND_BASE, int'(w)), rand_word(), h);
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      rst       = 1'b1;
      req_valid = 1'b0;
      req_op    = cache_pkg::OP_READ;
      req_addr  = '0;
      req_wdata = '0;
      ref_valid = '0;
      lfsr      = 32'h091f91bc;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      if (stall || rd_valid || hit) begin
         fail_run("Outputs were not low after reset");
      end
      write_through_no_alloc();
      fill_then_hit();
      write_hit_evict();
      conflict_thrash();
      random_mix();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- flist.f
+incdir+.
cache_pkg.sv
cache_ifs.sv
main_memory.sv
cache_data_array.sv
cache_tag_array.sv
cache_ctrl.sv
cache_top.sv
cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cache_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

out=$(./obj_dir/Vcache_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
